//--- src.f
+incdir+design
design/fpAddSubPkg.sv
design/alignStage.sv
design/leadZeroCount.sv
design/addNormStage.sv
design/roundStage.sv
design/fpAddSub.sv
bench/fpChecker.sv
bench/tbFpAddSub.sv

//--- bench/tbFpAddSub.sv
`timescale 1ns/10ps
`default_nettype none

`include "fpAddSub_defs.svh"

module tbFpAddSub;

	import fpAddSubPkg::*;

	localparam int ResetCycles = 5;
	localparam int NumExact    = 200;
	localparam int NumRound    = 300;
	localparam int NumCancel   = 40;                   // Five pairs each
	localparam int NumDirected = 14;
	localparam int TestCycles  = ResetCycles + 1 + NumExact + NumRound + 5 * NumCancel
		+ NumDirected + `PIPE_LATENCY + 3;
	localparam int CycleLimit  = TestCycles + 20;

	logic clk = 1'b0;
	logic rstN, operation;
	fpWordT a, b, result;
	logic [2:0] flags;
	int checkCount, errorCount;
	int cycleCount = 0;
	integer seed = 32'h6c07_5b96;

	always #50 clk = ~clk;                              // 100 ns period

	fpAddSub UUT (
		.clk (clk), .rstN (rstN), .a (a), .b (b), .operation (operation),
		.result (result), .flags (flags)
	);

	fpChecker uChecker (
		.clk (clk), .rstN (rstN), .a (a), .b (b), .operation (operation),
		.result (result), .flags (flags),
		.checkCount (checkCount), .errorCount (errorCount)
	);

	// One pair per falling edge, no gaps
	task automatic applyPair(input logic [31:0] x, input logic [31:0] y, input logic op);
		@(negedge clk);
		a         = x;
		b         = y;
		operation = op;
	endtask

	function automatic int randExp();
		return 64 + $unsigned($random(seed)) % 127;     // 64 to 190
	endfunction

	function automatic logic [31:0] randWord(input int expVal, input logic [22:0] fracMask);
		fpWordT w;
		w.fields.sign = $random(seed);
		w.fields.exp  = expVal[7:0];
		w.fields.frac = $random(seed) & fracMask;
		return w;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////
	initial begin
		int e1, e2;
		logic [31:0] x, y;
		rstN      = 1'b0;
		a         = '0;
		b         = '0;
		operation = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		// Low ten fraction bits clear, so the sums are exact
		for (int i = 0; i < NumExact; i++) begin
			e1 = randExp();
			e2 = e1 - $unsigned($random(seed)) % 9;
			if (e2 < 64)
				e2 = e2 + 9;
			x = randWord(e1, 23'h7F_FC00);
			y = randWord(e2, 23'h7F_FC00);
			applyPair((i % 2) ? y : x, (i % 2) ? x : y, $random(seed));
		end
		// Full fractions, near exponents on even turns
		for (int i = 0; i < NumRound; i++) begin
			e1 = randExp();
			e2 = (i % 2) ? randExp() : e1 - $unsigned($random(seed)) % 26;
			if (e2 < 64)
				e2 = e2 + 26;
			applyPair(randWord(e1, '1), randWord(e2, '1), $random(seed));
		end
		for (int i = 0; i < NumCancel; i++) begin
			x = randWord(randExp(), '1);
			y = x ^ ($unsigned($random(seed)) % 256);   // Same exponent, low bits off
			applyPair(x, x, 1'b1);                      // Gives +0
			applyPair(x ^ 32'h8000_0000, x, 1'b1);      // Doubles
			applyPair(x, x ^ 32'h8000_0000, 1'b0);
			applyPair(x, y, 1'b1);
			applyPair(x, {x[31], x[30:23] - 8'd1, ~x[22:0]}, 1'b1);
		end
		applyPair(32'h7FC0_0000, 32'h3F80_0000, 1'b0);  // NaN operand
		applyPair(32'h3F80_0000, 32'h7F80_0001, 1'b1);
		applyPair(32'h7F80_0000, 32'h7F80_0000, 1'b1);  // Inf - Inf
		applyPair(32'h7F80_0000, 32'hFF80_0000, 1'b0);
		applyPair(32'hFF80_0000, 32'h4000_0000, 1'b0);  // -Inf + 2
		applyPair(32'h4040_0000, 32'h7F80_0000, 1'b1);
		applyPair(32'h7F7F_FFFF, 32'h7F7F_FFFF, 1'b0);  // Overflow
		applyPair(32'hFF7F_FFFF, 32'h7F7F_FFFF, 1'b1);
		applyPair(32'h7F7F_FFFF, 32'h7300_0000, 1'b0);  // Tie at max rounds to Inf
		applyPair(32'h7F7F_FFFF, 32'h7280_0000, 1'b0);
		applyPair(32'h8000_0000, 32'h8000_0000, 1'b0);  // -0 + -0
		applyPair(32'h8000_0000, 32'h0000_0000, 1'b1);
		applyPair(32'h3F80_0000, 32'h3380_0000, 1'b0);  // Tie stays even
		applyPair(32'h3F80_0001, 32'h3380_0000, 1'b0);
		repeat (`PIPE_LATENCY + 2) @(negedge clk);     // Drain
		@(posedge clk);
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// Watchdog
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit) begin
			$display("Timeout: the run went past %0d clock cycles", CycleLimit);
			$display("Checks: %0d, errors: %0d", checkCount, errorCount);
			$display("sim failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- bench/fpChecker.sv
`timescale 1ns/10ps
`default_nettype none

`include "fpAddSub_defs.svh"

module fpChecker (
	input  wire                      clk,
	input  wire                      rstN,
	input  wire fpAddSubPkg::fpWordT a,
	input  wire fpAddSubPkg::fpWordT b,
	input  wire                      operation,
	input  wire fpAddSubPkg::fpWordT result,
	input  wire [2:0]                flags,
	output int                       checkCount,
	output int                       errorCount
);

	import fpAddSubPkg::*;

	logic [`FP_WIDTH+2:0] expectQ [0:`PIPE_LATENCY-1];   // Flags on top of the word
	logic [`PIPE_LATENCY-1:0] validQ = '0;               // Pair sampled out of reset
	logic [`FP_WIDTH+2:0] expected;

	// Single to double with exponent zero read as zero
	function automatic real toReal(input fpWordT w);
		if (w.fields.exp == '0)
			return 0.0;
		return $bitstoreal({w.fields.sign, 11'(w.fields.exp) + 11'd896, w.fields.frac, 29'd0});
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////
	function automatic logic [`FP_WIDTH+2:0] refAddSub(input fpWordT x, input fpWordT y,
			input logic op);
		logic xNan, yNan, xInf, yInf, guard, rest;
		real rx, ry, s, bv, err;
		logic [63:0] d;
		logic [24:0] sig;
		int se;
		xNan = (x.fields.exp == `EXP_MAX) && (x.fields.frac != '0);
		yNan = (y.fields.exp == `EXP_MAX) && (y.fields.frac != '0);
		xInf = (x.fields.exp == `EXP_MAX) && !xNan;
		yInf = (y.fields.exp == `EXP_MAX) && !yNan;
		if (xNan || yNan || (xInf && yInf && (x.fields.sign ^ y.fields.sign ^ op)))
			return {3'b010, `QNAN};
		if (xInf || yInf)                                // Infinity passes with overflow
			return {3'b100, xInf ? x.fields.sign : (y.fields.sign ^ op), `EXP_MAX, 23'd0};
		rx = toReal(x);
		ry = op ? -toReal(y) : toReal(y);
		// Two-sum error term holds what the double add dropped
		s   = rx + ry;
		bv  = s - rx;
		err = (rx - (s - bv)) + (ry - bv);
		if (s == 0.0)
			return {3'b000, x.fields.sign & (y.fields.sign ^ op), 31'd0};
		d  = $realtobits(s);
		se = int'(d[62:52]) - 896;                      // Rebias to single
		if (se < 1)
			return {3'b000, d[63], 31'd0};              // Below normal range
		guard = d[28];
		rest  = d[27:0] != '0;
		sig   = {2'b01, d[51:29]} + (guard & (rest | d[29]));    // Nearest even
		if (sig[24])
			se = se + 1;
		if (se >= 255)
			return {3'b101, d[63], `EXP_MAX, 23'd0};
		return {2'b00, guard | rest | (err != 0.0), d[63], 8'(se), sig[22:0]};
	endfunction

	initial begin
		checkCount = 0;
		errorCount = 0;
	end

	// Expected value rides through as many registers as the DUT
	always @(posedge clk) begin
		validQ      <= {validQ[`PIPE_LATENCY-2:0], rstN};
		expectQ[0]  <= refAddSub(a, b, operation);
		for (int i = 1; i < `PIPE_LATENCY; i++)
			expectQ[i] <= expectQ[i-1];
	end

	// Outputs are stable in the low phase
	always @(negedge clk) begin
		expected = validQ[`PIPE_LATENCY-1] ? expectQ[`PIPE_LATENCY-1] : '0;
		checkCount++;
		if ({flags, result.bits} !== expected) begin
			errorCount++;
			$display("Error at %0d ns: result %h flags %b, expected %h flags %b",
				$time, result.bits, flags,
				expected[`FP_WIDTH-1:0], expected[`FP_WIDTH+2:`FP_WIDTH]);
		end
	end

endmodule

`default_nettype wire

//--- design/fpAddSub.sv
`timescale 1ns/10ps
`default_nettype none

`include "fpAddSub_defs.svh"

module fpAddSub (
	input  wire                  clk,
	input  wire                  rstN,
	input  wire fpAddSubPkg::fpWordT a,
	input  wire fpAddSubPkg::fpWordT b,
	input  wire                  operation,    // 0 add, 1 subtract
	output fpAddSubPkg::fpWordT  result,
	output logic [2:0]           flags         // Overflow, invalid, inexact
);

	////////////////////////////////////////////////////////////////////////////
	// Stage 1 to stage 2
	////////////////////////////////////////////////////////////////////////////
	logic [`SIG_WIDTH-1:0]           sigMax;
	logic [`SIG_WIDTH+`EXT_BITS-1:0] sigMinAligned;
	logic [`EXP_WIDTH-1:0]           expMax;
	logic effSub, signMax, signA1, signB1, sub1;
	logic isNan1, isInf1, infConflict1;

	// Stage 2 to stage 3
	logic [`SIG_WIDTH+`EXT_BITS-1:0] normSig;
	logic [9:0] normExp;
	logic zeroSum, resSign;
	logic isNan2, isInf2, infConflict2;

	alignStage uAlign (
		.clk (clk), .rstN (rstN),
		.a (a), .b (b), .operation (operation),
		.sigMax (sigMax), .sigMinAligned (sigMinAligned), .expMax (expMax),
		.effSub (effSub), .signMax (signMax),
		.signA1 (signA1), .signB1 (signB1), .sub1 (sub1),
		.isNan1 (isNan1), .isInf1 (isInf1), .infConflict1 (infConflict1)
	);

	addNormStage uAddNorm (
		.clk (clk), .rstN (rstN),
		.sigMax (sigMax), .sigMinAligned (sigMinAligned), .expMax (expMax),
		.effSub (effSub), .signMax (signMax),
		.signA1 (signA1), .signB1 (signB1), .sub1 (sub1),
		.isNan1 (isNan1), .isInf1 (isInf1), .infConflict1 (infConflict1),
		.normSig (normSig), .normExp (normExp), .zeroSum (zeroSum), .resSign (resSign),
		.isNan2 (isNan2), .isInf2 (isInf2), .infConflict2 (infConflict2)
	);

	roundStage uRound (
		.clk (clk), .rstN (rstN),
		.normSig (normSig), .normExp (normExp), .zeroSum (zeroSum), .resSign (resSign),
		.isNan2 (isNan2), .isInf2 (isInf2), .infConflict2 (infConflict2),
		.result (result), .flags (flags)
	);

endmodule

`default_nettype wire

//--- design/roundStage.sv
`timescale 1ns/10ps
`default_nettype none

`include "fpAddSub_defs.svh"

module roundStage (
	input  wire                             clk,
	input  wire                             rstN,
	input  wire [`SIG_WIDTH+`EXT_BITS-1:0]  normSig,
	input  wire [9:0]                       normExp,
	input  wire                             zeroSum,
	input  wire                             resSign,
	input  wire                             isNan2,
	input  wire                             isInf2,
	input  wire                             infConflict2,
	output fpAddSubPkg::fpWordT             result,
	output logic [2:0]                      flags    // Overflow, invalid, inexact
);

	import fpAddSubPkg::*;

	logic [`SIG_WIDTH-1:0] sig;
	logic guard, roundSticky, roundUp;
	logic [`SIG_WIDTH:0] sigRounded;                    // Extra bit catches carry
	logic [9:0] expRounded;
	logic inexact, flushZero, expOverflow;
	fpWordT nextResult;
	logic [2:0] nextFlags;

	////////////////////////////////////////////////////////////////////////////
	// Round to nearest, ties to even
	////////////////////////////////////////////////////////////////////////////
	assign sig         = normSig[`SIG_WIDTH+`EXT_BITS-1:`EXT_BITS];
	assign guard       = normSig[`EXT_BITS-1];
	assign roundSticky = |normSig[`EXT_BITS-2:0];
	assign roundUp     = guard & (roundSticky | sig[0]);
	assign sigRounded  = {1'b0, sig} + {{`SIG_WIDTH{1'b0}}, roundUp};
	// Carry out leaves the fraction all zero and bumps the exponent
	assign expRounded  = normExp + {9'd0, sigRounded[`SIG_WIDTH]};

	assign inexact     = guard | roundSticky;
	assign flushZero   = $signed(normExp) < 10'sd1;          // Below normal range
	assign expOverflow = $signed(expRounded) >= $signed({2'b00, `EXP_MAX});

	always_comb begin
		nextResult.bits = '0;
		nextFlags       = 3'b000;
		if (isNan2 | infConflict2) begin
			nextResult.bits = `QNAN;
			nextFlags       = 3'b010;
		end else if (isInf2) begin
			// Inf operand passes through with overflow set
			nextResult.fields.sign = resSign;
			nextResult.fields.exp  = `EXP_MAX;
			nextFlags              = 3'b100;
		end else if (zeroSum | flushZero) begin
			nextResult.fields.sign = resSign;               // Signed zero
		end else if (expOverflow) begin
			nextResult.fields.sign = resSign;
			nextResult.fields.exp  = `EXP_MAX;
			nextFlags              = 3'b101;
		end else begin
			nextResult.fields.sign = resSign;
			nextResult.fields.exp  = expRounded[`EXP_WIDTH-1:0];
			nextResult.fields.frac = sigRounded[`MANT_WIDTH-1:0];
			nextFlags              = {2'b00, inexact};
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			result <= '0;
			flags  <= '0;
		end else begin
			result <= nextResult;
			flags  <= nextFlags;
		end
	end

endmodule

`default_nettype wire

//--- design/addNormStage.sv
`timescale 1ns/10ps
`default_nettype none

`include "fpAddSub_defs.svh"

module addNormStage (
	input  wire                             clk,
	input  wire                             rstN,
	input  wire [`SIG_WIDTH-1:0]            sigMax,
	input  wire [`SIG_WIDTH+`EXT_BITS-1:0]  sigMinAligned,
	input  wire [`EXP_WIDTH-1:0]            expMax,
	input  wire                             effSub,
	input  wire                             signMax,
	input  wire                             signA1,
	input  wire                             signB1,
	input  wire                             sub1,
	input  wire                             isNan1,
	input  wire                             isInf1,
	input  wire                             infConflict1,
	output logic [`SIG_WIDTH+`EXT_BITS-1:0] normSig,
	output logic [9:0]                      normExp,    // Signed, room both ways
	output logic                            zeroSum,
	output logic                            resSign,
	output logic                            isNan2,
	output logic                            isInf2,
	output logic                            infConflict2
);

	logic [`SIG_WIDTH+`EXT_BITS:0] extMax, extMin, rawSum, shifted;
	logic [4:0] zeroCount;
	logic sumIsZero;
	logic [9:0] expAdj;

	// Carry bit on top, GRS below
	assign extMax = {1'b0, sigMax, {`EXT_BITS{1'b0}}};
	assign extMin = {1'b0, sigMinAligned};
	assign rawSum = effSub ? (extMax - extMin) : (extMax + extMin);    // Never negative

	leadZeroCount uLzc (
		.rawSum    (rawSum),
		.zeroCount (zeroCount)
	);

	////////////////////////////////////////////////////////////////////////////
	// Normalize
	////////////////////////////////////////////////////////////////////////////
	assign shifted   = rawSum << zeroCount;                 // Leading one to the top
	assign sumIsZero = (rawSum == '0);
	assign expAdj    = {2'b00, expMax} + 10'd1 - {5'd0, zeroCount};

	always_ff @(posedge clk) begin
		if (!rstN) begin
			normSig      <= '0;
			normExp      <= '0;
			zeroSum      <= 1'b0;
			resSign      <= 1'b0;
			isNan2       <= 1'b0;
			isInf2       <= 1'b0;
			infConflict2 <= 1'b0;
		end else begin
			// Lowest two bits fold into sticky
			normSig      <= {shifted[`SIG_WIDTH+`EXT_BITS:2], |shifted[1:0]};
			normExp      <= expAdj;
			zeroSum      <= sumIsZero;
			// Exact zero is -0 only for (-x) + (-y)
			resSign      <= sumIsZero ? (signA1 & (signB1 ^ sub1)) : signMax;
			isNan2       <= isNan1;
			isInf2       <= isInf1;
			infConflict2 <= infConflict1;
		end
	end

endmodule

`default_nettype wire

//--- design/leadZeroCount.sv
`timescale 1ns/10ps
`default_nettype none

`include "fpAddSub_defs.svh"

module leadZeroCount (
	input  wire [`SIG_WIDTH+`EXT_BITS:0] rawSum,     // Carry bit on top
	output logic [4:0]                   zeroCount
);

	localparam int SumWidth = `SIG_WIDTH + `EXT_BITS + 1;

	////////////////////////////////////////////////////////////////////////////
	// Priority encoder, highest set bit wins
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		zeroCount = 5'(SumWidth);                     // All zero
		// Walk upward so the last hit is the leading one
		for (int i = 0; i < SumWidth; i++) begin
			if (rawSum[i]) begin
				zeroCount = 5'(SumWidth - 1 - i);
			end
		end
	end

endmodule

`default_nettype wire

//--- design/alignStage.sv
`timescale 1ns/10ps
`default_nettype none

`include "fpAddSub_defs.svh"

module alignStage (
	input  wire                             clk,
	input  wire                             rstN,
	input  wire fpAddSubPkg::fpWordT        a,
	input  wire fpAddSubPkg::fpWordT        b,
	input  wire                             operation,     // 1 = subtract
	output logic [`SIG_WIDTH-1:0]           sigMax,
	output logic [`SIG_WIDTH+`EXT_BITS-1:0] sigMinAligned,
	output logic [`EXP_WIDTH-1:0]           expMax,
	output logic                            effSub,
	output logic                            signMax,
	output logic                            signA1,
	output logic                            signB1,
	output logic                            sub1,
	output logic                            isNan1,
	output logic                            isInf1,
	output logic                            infConflict1
);

	localparam int ExtWidth = `SIG_WIDTH + `EXT_BITS;

	logic aNan, bNan, aInf, bInf, aZero, bZero;
	logic swap;                                            // b is the larger magnitude
	logic [`SIG_WIDTH-1:0] sigA, sigB, sigBig, sigSmall;
	logic [`EXP_WIDTH-1:0] expBig, expSmall, expDiff;
	logic [4:0] shiftAmt;
	logic [2*ExtWidth-1:0] shiftWin;                       // Upper half kept, lower half lost
	logic sticky;
	logic effSubNow;

	////////////////////////////////////////////////////////////////////////////
	// Classify operands
	////////////////////////////////////////////////////////////////////////////
	assign aNan  = (a.fields.exp == `EXP_MAX) && (a.fields.frac != '0);
	assign bNan  = (b.fields.exp == `EXP_MAX) && (b.fields.frac != '0);
	assign aInf  = (a.fields.exp == `EXP_MAX) && (a.fields.frac == '0);
	assign bInf  = (b.fields.exp == `EXP_MAX) && (b.fields.frac == '0);
	assign aZero = (a.fields.exp == '0);                  // Subnormals count as zero
	assign bZero = (b.fields.exp == '0);

	assign sigA = aZero ? '0 : {1'b1, a.fields.frac};
	assign sigB = bZero ? '0 : {1'b1, b.fields.frac};

	// Order by magnitude, exponent and fraction compare as one integer
	assign swap     = a.bits[`FP_WIDTH-2:0] < b.bits[`FP_WIDTH-2:0];
	assign sigBig   = swap ? sigB : sigA;
	assign sigSmall = swap ? sigA : sigB;
	assign expBig   = swap ? b.fields.exp : a.fields.exp;
	assign expSmall = swap ? a.fields.exp : b.fields.exp;

	assign effSubNow = operation ^ a.fields.sign ^ b.fields.sign;

	////////////////////////////////////////////////////////////////////////////
	// Align smaller significand
	////////////////////////////////////////////////////////////////////////////
	assign expDiff  = expBig - expSmall;
	assign shiftAmt = (expDiff > `SHIFT_SAT) ? 5'(`SHIFT_SAT) : expDiff[4:0];
	assign shiftWin = {sigSmall, {`EXT_BITS{1'b0}}, {ExtWidth{1'b0}}} >> shiftAmt;
	assign sticky   = |shiftWin[ExtWidth-1:0];            // Anything shifted out

	always_ff @(posedge clk) begin
		if (!rstN) begin
			sigMax        <= '0;
			sigMinAligned <= '0;
			expMax        <= '0;
			effSub        <= 1'b0;
			signMax       <= 1'b0;
			signA1        <= 1'b0;
			signB1        <= 1'b0;
			sub1          <= 1'b0;
			isNan1        <= 1'b0;
			isInf1        <= 1'b0;
			infConflict1  <= 1'b0;
		end else begin
			sigMax        <= sigBig;
			sigMinAligned <= {shiftWin[2*ExtWidth-1:ExtWidth+1], shiftWin[ExtWidth] | sticky};
			expMax        <= expBig;
			effSub        <= effSubNow;
			signMax       <= swap ? (b.fields.sign ^ operation) : a.fields.sign;
			signA1        <= a.fields.sign;
			signB1        <= b.fields.sign;
			sub1          <= operation;
			isNan1        <= aNan | bNan;
			isInf1        <= aInf | bInf;
			infConflict1  <= aInf & bInf & effSubNow;     // Inf - Inf
		end
	end

endmodule

`default_nettype wire

//--- design/fpAddSubPkg.sv
`default_nettype none

`include "fpAddSub_defs.svh"

package fpAddSubPkg;

	// One float word, seen either as raw bits or as its fields
	typedef union packed {
		logic [`FP_WIDTH-1:0] bits;
		struct packed {
			logic                   sign;    // 1 = negative
			logic [`EXP_WIDTH-1:0]  exp;     // Biased exponent
			logic [`MANT_WIDTH-1:0] frac;    // Hidden one not stored
		} fields;
	} fpWordT;

endpackage

`default_nettype wire

//--- design/fpAddSub_defs.svh
`ifndef FPADDSUB_DEFS_SVH
`define FPADDSUB_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Single precision word layout
////////////////////////////////////////////////////////////////////////////
`define FP_WIDTH     32           // Whole float word
`define EXP_WIDTH    8            // Biased exponent
`define MANT_WIDTH   23           // Stored fraction
`define SIG_WIDTH    24           // Fraction plus hidden one

// Guard, round and sticky below the significand
`define EXT_BITS     3

////////////////////////////////////////////////////////////////////////////
// Limits and special values
////////////////////////////////////////////////////////////////////////////
`define EXP_MAX      8'hFF        // Inf / NaN exponent
`define SHIFT_SAT    27           // Anything past this is pure sticky
`define QNAN         32'h7FC0_0000

// Input sample to result, in clock edges
`define PIPE_LATENCY 3

`endif
